/* design/ctrl_pkg.sv */
package ctrl_pkg;

    // host side widths
    localparam int phit_size    = 32;
    localparam int num_col      = 5;   // en 0 state table, 1..4 config tables
    localparam int num_cfg      = 4;
    localparam int dwidth_rfadd = 5;   // 32 entries per table
    localparam int dwidth_wadd  = 6;   // msb picks ctrl or imm half

    // column and loop widths
    localparam int ctrl_width    = 21;
    localparam int dwidth_int    = 32;
    localparam int dwidth_double = 64;

    typedef logic [dwidth_rfadd-1:0]  rf_addr_t;
    typedef logic [dwidth_wadd-1:0]   wr_addr_t;
    typedef logic [phit_size-1:0]     phit_t;
    typedef logic [ctrl_width-1:0]    ctrl_word_t;
    typedef logic [dwidth_int-1:0]    loop_cnt_t;
    typedef logic [dwidth_double-1:0] itr_t;

    // one loop program entry, msb first
    typedef struct packed {
        logic [7:0]              lim_i;     // outer trip count, 0 means 1
        logic [7:0]              lim_j;
        logic [7:0]              lim_k;     // inner trip count
        logic [dwidth_rfadd-1:0] next_ptr;
        logic                    last;
        logic [1:0]              spare;
    } state_entry_t;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        WAIT_STREAM,
        RUN,
        FINISH
    } seq_state_t;

endpackage

/* design/state_table.sv */
`timescale 1ns/10ps

module state_table (
    input  logic                    clk,
    input  ctrl_pkg::wr_addr_t      wr_add,
    input  logic                    wr_en,
    input  ctrl_pkg::phit_t         wr_data,
    input  ctrl_pkg::rf_addr_t      rd_add,
    output ctrl_pkg::state_entry_t  rd_data
);

    localparam int depth = 2 ** ctrl_pkg::dwidth_rfadd;

    ctrl_pkg::state_entry_t mem [0:depth-1];

    // host write, bit 5 of the address is don't care here
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_add[ctrl_pkg::dwidth_rfadd-1:0]] <= ctrl_pkg::state_entry_t'(wr_data);
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_add];  // one cycle read latency
    end

endmodule

/* design/config_table.sv */
`timescale 1ns/10ps

module config_table (
    input  logic                  clk,
    input  ctrl_pkg::wr_addr_t    wr_add,
    input  logic                  wr_en,
    input  ctrl_pkg::phit_t       wr_data,
    input  ctrl_pkg::rf_addr_t    rd_add,
    output ctrl_pkg::ctrl_word_t  rd_data_ctrl,
    output ctrl_pkg::phit_t       rd_data_imm
);

    localparam int depth = 2 ** ctrl_pkg::dwidth_rfadd;

    ctrl_pkg::ctrl_word_t mem_ctrl [0:depth-1];
    ctrl_pkg::phit_t      mem_imm  [0:depth-1];

    ctrl_pkg::rf_addr_t wr_entry;
    logic               wr_imm_half;

    assign wr_entry    = wr_add[ctrl_pkg::dwidth_rfadd-1:0];
    assign wr_imm_half = wr_add[ctrl_pkg::dwidth_wadd-1];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            if (wr_imm_half) begin
                mem_imm[wr_entry] <= wr_data;
            end else begin
                mem_ctrl[wr_entry] <= wr_data[ctrl_pkg::ctrl_width-1:0];  // low bits only
            end
        end
    end

    // both halves read together at the entry pointer
    always_ff @(posedge clk) begin
        rd_data_ctrl <= mem_ctrl[rd_add];
        rd_data_imm  <= mem_imm[rd_add];
    end

endmodule

/* design/loop_sequencer.sv */
`timescale 1ns/10ps

module loop_sequencer (
    input  logic                    clk,
    input  logic                    rst,
    input  ctrl_pkg::state_entry_t  entry_table,
    input  logic                    start_inbound,
    input  logic                    start_stream_in,
    output ctrl_pkg::rf_addr_t      smart_ptr,
    output ctrl_pkg::loop_cnt_t     itr_k,
    output logic                    fire,
    output logic                    ready,
    output logic                    done
);

    ctrl_pkg::seq_state_t state;

    ctrl_pkg::loop_cnt_t cnt_i;  // outer
    ctrl_pkg::loop_cnt_t cnt_j;
    ctrl_pkg::loop_cnt_t cnt_k;  // inner

    ctrl_pkg::loop_cnt_t lim_i_eff;
    ctrl_pkg::loop_cnt_t lim_j_eff;
    ctrl_pkg::loop_cnt_t lim_k_eff;

    logic go_taken;  // stream go already seen for this program
    logic k_wrap;
    logic j_wrap;
    logic i_wrap;

    // a trip count of zero still runs once
    function automatic ctrl_pkg::loop_cnt_t eff_lim(input logic [7:0] lim);
        ctrl_pkg::loop_cnt_t res;
        res = ctrl_pkg::loop_cnt_t'(lim);
        if (lim == 8'd0) begin
            res = ctrl_pkg::loop_cnt_t'(1);
        end
        return res;
    endfunction

    assign lim_i_eff = eff_lim(entry_table.lim_i);
    assign lim_j_eff = eff_lim(entry_table.lim_j);
    assign lim_k_eff = eff_lim(entry_table.lim_k);

    assign k_wrap = (cnt_k == lim_k_eff - 1'b1);
    assign j_wrap = (cnt_j == lim_j_eff - 1'b1);
    assign i_wrap = (cnt_i == lim_i_eff - 1'b1);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ctrl_pkg::IDLE;
            smart_ptr <= '0;
            cnt_i     <= '0;
            cnt_j     <= '0;
            cnt_k     <= '0;
            go_taken  <= 1'b0;
        end else begin
            case (state)
                ctrl_pkg::IDLE: begin
                    if (start_inbound) begin
                        smart_ptr <= '0;       // program always begins at entry 0
                        go_taken  <= 1'b0;
                        state     <= ctrl_pkg::FETCH;
                    end
                end
                ctrl_pkg::FETCH: begin
                    cnt_i <= '0;
                    cnt_j <= '0;
                    cnt_k <= '0;
                    state <= go_taken ? ctrl_pkg::RUN : ctrl_pkg::WAIT_STREAM;
                end
                ctrl_pkg::WAIT_STREAM: begin
                    if (start_stream_in) begin
                        go_taken <= 1'b1;
                        state    <= ctrl_pkg::RUN;
                    end
                end
                ctrl_pkg::RUN: begin
                    if (!k_wrap) begin
                        cnt_k <= cnt_k + 1'b1;
                    end else begin
                        cnt_k <= '0;
                        if (!j_wrap) begin
                            cnt_j <= cnt_j + 1'b1;
                        end else begin
                            cnt_j <= '0;
                            if (!i_wrap) begin
                                cnt_i <= cnt_i + 1'b1;
                            end else begin
                                // entry complete
                                cnt_i <= '0;
                                if (entry_table.last) begin
                                    state <= ctrl_pkg::FINISH;
                                end else begin
                                    smart_ptr <= entry_table.next_ptr;
                                    state     <= ctrl_pkg::FETCH;
                                end
                            end
                        end
                    end
                end
                ctrl_pkg::FINISH: state <= ctrl_pkg::IDLE;
                default:          state <= ctrl_pkg::IDLE;
            endcase
        end
    end

    assign itr_k = cnt_k;
    assign fire  = (state == ctrl_pkg::RUN);
    assign ready = (state == ctrl_pkg::WAIT_STREAM);
    assign done  = (state == ctrl_pkg::FINISH);

    // stream go and iteration strobe are mutually exclusive
    a_ready_fire: assert property (@(posedge clk) disable iff (rst)
        !(ready && fire));

    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        done |=> !done);

    // table outputs must not move under a running entry
    a_ptr_stable: assert property (@(posedge clk) disable iff (rst)
        fire |=> (!fire || $stable(smart_ptr)));

endmodule

/* design/control_plane.sv */
`timescale 1ns/10ps

module control_plane (
    input  logic                                         clk,
    input  logic                                         rst,
    input  ctrl_pkg::wr_addr_t                           wr_add,
    input  logic [ctrl_pkg::num_col-1:0]                 wr_en,
    input  ctrl_pkg::phit_t                              wr_data,
    output ctrl_pkg::ctrl_word_t [ctrl_pkg::num_cfg-1:0] rd_data_ctrl,  // column 0 lowest
    output ctrl_pkg::phit_t [ctrl_pkg::num_cfg-1:0]      rd_data_imm,
    output ctrl_pkg::state_entry_t                       rd_data_state,
    output ctrl_pkg::itr_t                               itr,
    output logic                                         fire,
    input  logic                                         start_inbound,
    input  logic                                         start_stream_in,
    output logic                                         ready,
    output logic                                         done
);

    ctrl_pkg::rf_addr_t  smart_ptr;  // shared read pointer for every table
    ctrl_pkg::loop_cnt_t itr_k;
    logic                busy;

    state_table u_state_table (
        .clk     (clk),
        .wr_add  (wr_add),
        .wr_en   (wr_en[0]),
        .wr_data (wr_data),
        .rd_add  (smart_ptr),
        .rd_data (rd_data_state)
    );

    // one config table per column, enables 1..4
    for (genvar c = 0; c < ctrl_pkg::num_cfg; c++) begin : g_cfg
        config_table u_config_table (
            .clk          (clk),
            .wr_add       (wr_add),
            .wr_en        (wr_en[c+1]),
            .wr_data      (wr_data),
            .rd_add       (smart_ptr),
            .rd_data_ctrl (rd_data_ctrl[c]),
            .rd_data_imm  (rd_data_imm[c])
        );
    end

    loop_sequencer u_loop_sequencer (
        .clk             (clk),
        .rst             (rst),
        .entry_table     (rd_data_state),
        .start_inbound   (start_inbound),
        .start_stream_in (start_stream_in),
        .smart_ptr       (smart_ptr),
        .itr_k           (itr_k),
        .fire            (fire),
        .ready           (ready),
        .done            (done)
    );

    // only the inner index is exported
    assign itr = ctrl_pkg::itr_t'(itr_k);

    // program in flight, from accepted start to done
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (done) begin
            busy <= 1'b0;
        end else if (start_inbound) begin
            busy <= 1'b1;
        end
    end

    a_no_write_busy: assert property (@(posedge clk) disable iff (rst)
        busy |-> (wr_en == '0));

endmodule

/* sim/tb_control_plane.sv */
`timescale 1ns/10ps

module tb_control_plane;

    // one expected clock cycle as seen at the falling edge
    typedef struct packed {
        logic                fire;
        logic                ready;
        logic                done;
        ctrl_pkg::rf_addr_t  ptr;
        ctrl_pkg::loop_cnt_t k;
    } cycle_exp_t;

    logic                                         clk = 1'b0;
    logic                                         rst;
    ctrl_pkg::wr_addr_t                           wr_add;
    logic [ctrl_pkg::num_col-1:0]                 wr_en;
    ctrl_pkg::phit_t                              wr_data;
    ctrl_pkg::ctrl_word_t [ctrl_pkg::num_cfg-1:0] rd_data_ctrl;
    ctrl_pkg::phit_t [ctrl_pkg::num_cfg-1:0]      rd_data_imm;
    ctrl_pkg::state_entry_t                       rd_data_state;
    ctrl_pkg::itr_t                               itr;
    logic                                         fire;
    logic                                         start_inbound;
    logic                                         start_stream_in;
    logic                                         ready;
    logic                                         done;

    // reference copies of every table
    ctrl_pkg::state_entry_t m_state [0:31];
    ctrl_pkg::ctrl_word_t   m_ctrl  [0:ctrl_pkg::num_cfg-1][0:31];
    ctrl_pkg::phit_t        m_imm   [0:ctrl_pkg::num_cfg-1][0:31];

    cycle_exp_t  sched [$];
    logic [31:0] rng_state = 32'd55;
    int          cycle_cnt = 0;
    int          deadline  = 100;  // covers reset until the first program sets it
    int          fire_expected;

    control_plane dut_i (
        .clk             (clk),
        .rst             (rst),
        .wr_add          (wr_add),
        .wr_en           (wr_en),
        .wr_data         (wr_data),
        .rd_data_ctrl    (rd_data_ctrl),
        .rd_data_imm     (rd_data_imm),
        .rd_data_state   (rd_data_state),
        .itr             (itr),
        .fire            (fire),
        .start_inbound   (start_inbound),
        .start_stream_in (start_stream_in),
        .ready           (ready),
        .done            (done)
    );

    always #4 clk = ~clk;  // 8 ns period

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // zero trips still run once
    function automatic int trip_count(input logic [7:0] lim);
        return (lim == 8'd0) ? 1 : int'(lim);
    endfunction

    task automatic report_mismatch(input string name, input logic [127:0] exp_val,
                                   input logic [127:0] act_val);
        $display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, exp_val, act_val);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    // one host write, model updated alongside
    task automatic write_word(input int en_idx, input ctrl_pkg::wr_addr_t addr,
                              input ctrl_pkg::phit_t data);
        logic [ctrl_pkg::num_col-1:0] en_bits;
        ctrl_pkg::rf_addr_t           entry;
        en_bits         = '0;
        en_bits[en_idx] = 1'b1;
        entry           = addr[ctrl_pkg::dwidth_rfadd-1:0];
        @(posedge clk);
        wr_en   <= en_bits;
        wr_add  <= addr;
        wr_data <= data;
        if (en_idx == 0) begin
            m_state[entry] = ctrl_pkg::state_entry_t'(data);
        end else if (addr[ctrl_pkg::dwidth_wadd-1]) begin
            m_imm[en_idx-1][entry] = data;
        end else begin
            m_ctrl[en_idx-1][entry] = data[ctrl_pkg::ctrl_width-1:0];
        end
        @(negedge clk);
        // sequencer must sit quiet while idle
        assert (ready == 1'b0) else report_mismatch("ready", 1'b0, ready);
        assert (fire == 1'b0) else report_mismatch("fire", 1'b0, fire);
        assert (done == 1'b0) else report_mismatch("done", 1'b0, done);
    endtask

    task automatic load_tables(input int len);
        logic [31:0]            used;
        ctrl_pkg::rf_addr_t     chain [0:4];
        ctrl_pkg::rf_addr_t     cand;
        ctrl_pkg::state_entry_t ent;
        used     = 32'd1;  // entry 0 always starts the chain
        chain[0] = '0;
        for (int n = 1; n < len; n++) begin
            cand = ctrl_pkg::rf_addr_t'(next_random() % 31 + 1);
            while (used[cand]) begin
                cand = (cand == 5'd31) ? 5'd1 : cand + 1'b1;
            end
            used[cand] = 1'b1;
            chain[n]   = cand;
        end
        for (int a = 0; a < 32; a++) begin
            write_word(0, ctrl_pkg::wr_addr_t'(a), next_random());  // filler entries
        end
        for (int n = 0; n < len; n++) begin
            ent       = ctrl_pkg::state_entry_t'(next_random());
            ent.lim_i = 8'(next_random() % 5);
            ent.lim_j = 8'(next_random() % 5);
            ent.lim_k = 8'(next_random() % 5);
            ent.last  = (n == len - 1);
            if (n < len - 1) begin
                ent.next_ptr = chain[n+1];
            end
            write_word(0, {1'b0, chain[n]}, ent);
        end
        // both halves of all four columns
        for (int c = 1; c <= ctrl_pkg::num_cfg; c++) begin
            for (int a = 0; a < 64; a++) begin
                write_word(c, ctrl_pkg::wr_addr_t'(a), next_random());
            end
        end
        @(posedge clk);
        wr_en <= '0;
    endtask

    // walk the program by the timing rules, one item per cycle
    task automatic build_schedule(input bit early, input int d);
        ctrl_pkg::rf_addr_t     ptr;
        ctrl_pkg::state_entry_t ent;
        int                     n_ready;
        sched.delete();
        fire_expected = 0;
        n_ready       = early ? 1 : d + 2;
        sched.push_back('{fire: 1'b0, ready: 1'b0, done: 1'b0, ptr: '0, k: '0});  // idle
        sched.push_back('{fire: 1'b0, ready: 1'b0, done: 1'b0, ptr: '0, k: '0});  // fetch
        repeat (n_ready) begin
            sched.push_back('{fire: 1'b0, ready: 1'b1, done: 1'b0, ptr: '0, k: '0});
        end
        ptr = '0;
        for (int e = 0; e < 32; e++) begin
            ent = m_state[ptr];
            fire_expected += trip_count(ent.lim_i) * trip_count(ent.lim_j)
                             * trip_count(ent.lim_k);
            for (int i = 0; i < trip_count(ent.lim_i); i++) begin
                for (int j = 0; j < trip_count(ent.lim_j); j++) begin
                    for (int k = 0; k < trip_count(ent.lim_k); k++) begin
                        sched.push_back('{fire: 1'b1, ready: 1'b0, done: 1'b0, ptr: ptr,
                                          k: ctrl_pkg::loop_cnt_t'(k)});
                    end
                end
            end
            if (ent.last) begin
                break;
            end
            sched.push_back('{fire: 1'b0, ready: 1'b0, done: 1'b0, ptr: '0, k: '0});
            ptr = ent.next_ptr;
        end
        sched.push_back('{fire: 1'b0, ready: 1'b0, done: 1'b1, ptr: '0, k: '0});
        sched.push_back('{fire: 1'b0, ready: 1'b0, done: 1'b0, ptr: '0, k: '0});  // back idle
    endtask

    task automatic check_iteration(input cycle_exp_t ex);
        ctrl_pkg::ctrl_word_t [ctrl_pkg::num_cfg-1:0] exp_ctrl;
        ctrl_pkg::phit_t [ctrl_pkg::num_cfg-1:0]      exp_imm;
        for (int c = 0; c < ctrl_pkg::num_cfg; c++) begin
            exp_ctrl[c] = m_ctrl[c][ex.ptr];
            exp_imm[c]  = m_imm[c][ex.ptr];
        end
        assert (itr == {32'h0, ex.k}) else report_mismatch("itr", {32'h0, ex.k}, itr);
        assert (rd_data_state == m_state[ex.ptr])
            else report_mismatch("rd_data_state", m_state[ex.ptr], rd_data_state);
        assert (rd_data_ctrl == exp_ctrl)
            else report_mismatch("rd_data_ctrl", exp_ctrl, rd_data_ctrl);
        assert (rd_data_imm == exp_imm)
            else report_mismatch("rd_data_imm", exp_imm, rd_data_imm);
    endtask

    task automatic run_program(input bit early, input int d);
        int         go_idx;
        int         first_fire;
        int         fires_seen;
        cycle_exp_t ex;
        go_idx     = early ? 0 : d + 3;  // early go rides along with the start
        first_fire = early ? 3 : d + 4;
        fires_seen = 0;
        for (int idx = 0; idx < sched.size(); idx++) begin
            ex = sched[idx];
            @(posedge clk);
            start_inbound <= (idx == 0);
            if (idx == go_idx) begin
                start_stream_in <= 1'b1;
            end
            if (idx == first_fire) begin
                start_stream_in <= 1'b0;  // go was sampled on this edge
            end
            @(negedge clk);
            assert (ready == ex.ready) else report_mismatch("ready", ex.ready, ready);
            assert (fire == ex.fire) else report_mismatch("fire", ex.fire, fire);
            assert (done == ex.done) else report_mismatch("done", ex.done, done);
            if (fire) begin
                fires_seen++;
                check_iteration(ex);
            end
        end
        assert (fires_seen == fire_expected)
            else report_mismatch("fire count", fire_expected, fires_seen);
    endtask

    initial begin
        wait (cycle_cnt > deadline);
        $display("Timeout: the run did not finish after %0d cycles", cycle_cnt);
        $display("=== FAIL ===");
        $fatal(1);
    end

    initial begin
        int len;
        int d;
        bit early;
        rst             = 1'b1;
        wr_add          = '0;
        wr_en           = '0;
        wr_data         = '0;
        start_inbound   = 1'b0;
        start_stream_in = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (int p = 0; p < 6; p++) begin
            len   = next_random() % 5 + 1;
            d     = next_random() % 6;
            early = (p % 2 == 0);
            // 32 state writes, 256 column writes
            deadline = cycle_cnt + 2 * (32 + len + 256 + 2) + 200;
            load_tables(len);
            build_schedule(early, d);
            deadline = cycle_cnt + 2 * sched.size() + 200;
            run_program(early, d);
            $display("program %0d: %0d entries, %0d iterations", p, len, fire_expected);
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* files.f */
design/ctrl_pkg.sv
design/state_table.sv
design/config_table.sv
design/loop_sequencer.sv
design/control_plane.sv
sim/tb_control_plane.sv

/* Bender.yml */
package:
  name: control_plane

sources:
  - files:
      - design/ctrl_pkg.sv
      - design/state_table.sv
      - design/config_table.sv
      - design/loop_sequencer.sv
      - design/control_plane.sv
  - target: simulation
    files:
      - sim/tb_control_plane.sv
